/* Bender.yml */
package:
  name: exu

sources:
  - logic/exu_pkg.sv
  - logic/exu_regfile.sv
  - logic/exu_decode.sv
  - logic/exu_disp.sv
  - logic/exu_oitf.sv
  - logic/exu_alu.sv
  - logic/exu_wbck.sv
  - logic/exu_commit.sv
  - logic/exu_top.sv
  - target: test
    files:
      - tb/tb_exu.sv

/* flist.f */
logic/exu_pkg.sv
logic/exu_regfile.sv
logic/exu_decode.sv
logic/exu_disp.sv
logic/exu_oitf.sv
logic/exu_alu.sv
logic/exu_wbck.sv
logic/exu_commit.sv
logic/exu_top.sv
tb/tb_exu.sv

/* logic/exu_alu.sv */
/* Single-cycle integer ALU plus load address generation.
   The address is rs1 plus the I-type immediate, no alignment check. */

`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic            i_valid,
  input  dec_info_t       i_info,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  output rf_wbck_t        o_wbck_req,
  output logic [XLEN-1:0] o_agu_addr
);

  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] res;

  assign op2 = i_info.use_imm ? i_info.imm : i_rs2;

  always_comb begin
    case (i_info.alu_op)
      ALU_ADD: res = i_rs1 + op2;
      ALU_SUB: res = i_rs1 - op2;
      ALU_AND: res = i_rs1 & op2;
      ALU_OR:  res = i_rs1 | op2;
      ALU_XOR: res = i_rs1 ^ op2;
      default: res = '0;
    endcase
  end

  // Write request, same cycle as dispatch
  assign o_wbck_req.ena  = i_valid & i_info.rdwen;
  assign o_wbck_req.idx  = i_info.rdidx;
  assign o_wbck_req.wdat = res;

  // AGU
  assign o_agu_addr = i_rs1 + i_info.imm;

endmodule

/* logic/exu_commit.sv */
/* Trap commit for illegal instructions: drain the OITF, then flush.
   The flush request holds until i_flush_ack is sampled high. */

`timescale 1ns/1ps

module exu_commit import exu_pkg::*; (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_trap_ena,
  input  logic [XLEN-1:0] i_trap_pc,
  input  logic            i_oitf_empty,
  input  logic            i_flush_ack,
  output logic            o_run,
  output logic            o_commit_trap,
  output logic            o_flush_req,
  output logic [XLEN-1:0] o_flush_pc
);

  typedef enum logic [1:0] {
    ST_RUN   = 2'd0,
    ST_DRAIN = 2'd1,  // Older loads still in flight
    ST_FLUSH = 2'd2   // Waiting for the acknowledge
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   drain_done;

  assign drain_done = (state_q == ST_DRAIN) & i_oitf_empty;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN:   if (i_trap_ena) state_d = ST_DRAIN;
      ST_DRAIN: if (i_oitf_empty) state_d = i_flush_ack ? ST_RUN : ST_FLUSH;
      ST_FLUSH: if (i_flush_ack) state_d = ST_RUN;
      default:  state_d = ST_RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // PC of the trapping instruction
  always_ff @(posedge clk) begin
    if (i_trap_ena && (state_q == ST_RUN)) o_flush_pc <= i_trap_pc;
  end

  assign o_run         = (state_q == ST_RUN);
  assign o_commit_trap = drain_done;            // DRAIN is left on the same edge
  assign o_flush_req   = drain_done | (state_q == ST_FLUSH);

endmodule

/* logic/exu_decode.sv */
/* Decoder for ADD, SUB, AND, OR, XOR, ADDI and LW.
   Any other encoding is flagged illegal with all register enables cleared. */

`timescale 1ns/1ps

module exu_decode import exu_pkg::*; (
  input  instr_t    i_ir,
  output dec_info_t o_info
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_ir[6:0];
  assign funct3 = i_ir[14:12];
  assign funct7 = i_ir[31:25];

  always_comb begin
    o_info         = '0;
    o_info.alu_op  = ALU_ADD;
    o_info.rdidx   = i_ir[11:7];
    o_info.rs1idx  = i_ir[19:15];
    o_info.rs2idx  = i_ir[24:20];
    o_info.imm     = {{(XLEN-12){i_ir[31]}}, i_ir[31:20]};

    case (opcode)
      OPC_OP: begin
        o_info.rs1en = 1'b1;
        o_info.rs2en = 1'b1;
        o_info.rdwen = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_info.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: o_info.alu_op = ALU_SUB;
          {7'b0000000, 3'b100}: o_info.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: o_info.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: o_info.alu_op = ALU_AND;
          default:              o_info.ilegl  = 1'b1;
        endcase
      end
      OPC_OPIMM: begin  // ADDI only
        o_info.rs1en   = 1'b1;
        o_info.rdwen   = 1'b1;
        o_info.use_imm = 1'b1;
        o_info.ilegl   = (funct3 != 3'b000);
      end
      OPC_LOAD: begin   // LW only
        o_info.rs1en   = 1'b1;
        o_info.rdwen   = 1'b1;
        o_info.use_imm = 1'b1;
        o_info.is_load = (funct3 == 3'b010);
        o_info.ilegl   = (funct3 != 3'b010);
      end
      default: o_info.ilegl = 1'b1;
    endcase

    // x0 never creates a dependency or a write
    o_info.rs1en = o_info.rs1en & ~o_info.ilegl & (o_info.rs1idx != '0);
    o_info.rs2en = o_info.rs2en & ~o_info.ilegl & (o_info.rs2idx != '0);
    o_info.rdwen = o_info.rdwen & ~o_info.ilegl & (o_info.rdidx != '0);
  end

endmodule

/* logic/exu_disp.sv */
/* Dispatch with the one stall equation of the stage.
   Steers each accepted instruction to the ALU, the OITF with the load command, or commit. */

`timescale 1ns/1ps

module exu_disp import exu_pkg::*; (
  input  logic            i_valid,
  input  logic [XLEN-1:0] i_pc,
  input  dec_info_t       i_info,
  input  logic            i_oitf_full,
  input  logic            i_match_rs1,   // Already qualified by the source enables
  input  logic            i_match_rs2,
  input  logic            i_match_rd,
  input  logic            i_agu_cmd_ready,
  input  logic            i_lsu_busy,
  input  logic            i_run,
  output logic            o_ready,
  output logic            o_alu_valid,
  output logic            o_oitf_ena,
  output logic            o_agu_cmd_valid,
  output logic            o_trap_ena,
  output logic [XLEN-1:0] o_trap_pc
);

  logic dep_stall;   // RAW or WAW against an outstanding load
  logic load_room;   // OITF has a free entry
  logic path_ok;
  logic disp_hsk;

  assign dep_stall = i_match_rs1 | i_match_rs2 | (i_info.rdwen & i_match_rd);
  assign load_room = ~i_oitf_full;

  // Per-class condition. Loads need the command channel in the same cycle,
  // ALU ops lose to a returning load at the write port
  always_comb begin
    if (i_info.is_load) begin
      path_ok = load_room & i_agu_cmd_ready;
    end else if (i_info.ilegl) begin
      path_ok = 1'b1;
    end else begin
      path_ok = ~i_lsu_busy;
    end
  end

  assign o_ready  = i_run & ~dep_stall & path_ok;
  assign disp_hsk = i_valid & o_ready;

  // Command valid must not look at the command ready
  assign o_agu_cmd_valid = i_valid & i_info.is_load & i_run & ~dep_stall & load_room;

  assign o_alu_valid = disp_hsk & ~i_info.is_load & ~i_info.ilegl;
  assign o_oitf_ena  = disp_hsk & i_info.is_load;
  assign o_trap_ena  = disp_hsk & i_info.ilegl;
  assign o_trap_pc   = i_pc;

endmodule

/* logic/exu_oitf.sv */
/* Outstanding-load FIFO; OITF_DEPTH must be a power of two, 2 or more.
   Entries retire strictly in allocation order. */

`timescale 1ns/1ps

module exu_oitf import exu_pkg::*; #(
  parameter int OITF_DEPTH = 4
) (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_disp_ena,
  input  logic [RFIDX_W-1:0] i_disp_rdidx,
  input  logic               i_rs1en,
  input  logic [RFIDX_W-1:0] i_rs1idx,
  input  logic               i_rs2en,
  input  logic [RFIDX_W-1:0] i_rs2idx,
  input  logic               i_ret_ena,
  output logic               o_full,
  output logic               o_empty,
  output logic [RFIDX_W-1:0] o_ret_rdidx,
  output logic               o_match_rs1,
  output logic               o_match_rs2,
  output logic               o_match_rd
);

  localparam int PTR_W = $clog2(OITF_DEPTH);

  logic [PTR_W-1:0]   wptr_q;
  logic [PTR_W-1:0]   rptr_q;
  logic [PTR_W:0]     cnt_q;       // Occupancy, 0 to OITF_DEPTH
  logic [OITF_DEPTH-1:0] vld_q;
  logic [RFIDX_W-1:0] rdidx_q [OITF_DEPTH];

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
      vld_q  <= '0;
    end else begin
      if (i_ret_ena) begin
        rptr_q        <= rptr_q + 1'b1;
        vld_q[rptr_q] <= 1'b0;
      end
      if (i_disp_ena) begin
        wptr_q        <= wptr_q + 1'b1;
        vld_q[wptr_q] <= 1'b1;   // Never the head being freed, FIFO is not full
      end
      case ({i_disp_ena, i_ret_ena})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_disp_ena) rdidx_q[wptr_q] <= i_disp_rdidx;
  end

  assign o_full      = (cnt_q == (PTR_W+1)'(OITF_DEPTH));
  assign o_empty     = (cnt_q == '0);
  assign o_ret_rdidx = rdidx_q[rptr_q];

  ////////////////////////////////////////////////////////////
  // Destination compare against every live entry
  always_comb begin
    o_match_rs1 = 1'b0;
    o_match_rs2 = 1'b0;
    o_match_rd  = 1'b0;
    for (int i = 0; i < OITF_DEPTH; i++) begin
      o_match_rs1 |= vld_q[i] & i_rs1en & (rdidx_q[i] == i_rs1idx);
      o_match_rs2 |= vld_q[i] & i_rs2en & (rdidx_q[i] == i_rs2idx);
      o_match_rd  |= vld_q[i] & (rdidx_q[i] == i_disp_rdidx);
    end
  end

endmodule

/* logic/exu_pkg.sv */
/* Shared widths and types for the RV32 execution stage.
   Only ADD, SUB, AND, OR, XOR, ADDI and LW are decoded; everything else traps. */

package exu_pkg;

  localparam int XLEN    = 32;
  localparam int RFIDX_W = 5;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;

  typedef logic [31:0] instr_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Decoded instruction, consumed by dispatch, OITF and ALU
  typedef struct packed {
    alu_op_e              alu_op;
    logic                 use_imm;  // Operand 2 from the immediate
    logic                 is_load;  // Long-pipe, goes through the OITF
    logic                 ilegl;
    logic                 rs1en;    // Low for x0, no hazard possible
    logic                 rs2en;
    logic                 rdwen;    // Low for x0 destinations
    logic [RFIDX_W-1:0]   rs1idx;
    logic [RFIDX_W-1:0]   rs2idx;
    logic [RFIDX_W-1:0]   rdidx;
    logic [XLEN-1:0]      imm;      // I-type, sign extended
  } dec_info_t;

  // One register file write
  typedef struct packed {
    logic                 ena;
    logic [RFIDX_W-1:0]   idx;
    logic [XLEN-1:0]      wdat;
  } rf_wbck_t;

endpackage

/* logic/exu_regfile.sv */
/* Integer register file, 31 entries, x0 reads as zero.
   Reads are combinational, a write is visible after the next edge. */

`timescale 1ns/1ps

module exu_regfile import exu_pkg::*; (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic [RFIDX_W-1:0] i_rs1idx,
  input  logic [RFIDX_W-1:0] i_rs2idx,
  input  rf_wbck_t           i_wbck,
  output logic [XLEN-1:0]    o_rs1,
  output logic [XLEN-1:0]    o_rs2
);

  logic [XLEN-1:0] rf_q [1:31];  // No storage behind x0

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wbck.ena && (i_wbck.idx != '0)) begin
      rf_q[i_wbck.idx] <= i_wbck.wdat;
    end
  end

  // x0 is hardwired
  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

/* logic/exu_top.sv */
/* Execution stage top: regfile, decode, dispatch, OITF, ALU, write-back, commit.
   Instruction source must hold i_valid and its data until o_ready. */

`timescale 1ns/1ps

module exu_top import exu_pkg::*; #(
  parameter int OITF_DEPTH = 4
) (
  input  logic            clk,
  input  logic            i_rst_n,
  // Instruction in
  input  logic            i_valid,
  output logic            o_ready,
  input  instr_t          i_ir,
  input  logic [XLEN-1:0] i_pc,
  // Load command out
  output logic            o_agu_cmd_valid,
  input  logic            i_agu_cmd_ready,
  output logic [XLEN-1:0] o_agu_cmd_addr,
  // Load write-back in, in command order
  input  logic            i_lsu_valid,
  output logic            o_lsu_ready,
  input  logic [XLEN-1:0] i_lsu_wdat,
  // Flush
  output logic            o_flush_req,
  input  logic            i_flush_ack,
  output logic [XLEN-1:0] o_flush_pc,
  // Status and trace
  output logic            o_commit_trap,
  output logic            o_oitf_empty,
  output logic            o_exu_active,
  output rf_wbck_t        o_wbck
);

  dec_info_t          dec_info;
  logic [XLEN-1:0]    rf_rs1;
  logic [XLEN-1:0]    rf_rs2;
  logic               oitf_full;
  logic               match_rs1;
  logic               match_rs2;
  logic               match_rd;
  logic [RFIDX_W-1:0] ret_rdidx;
  logic               ret_ena;
  logic               lsu_busy;
  logic               run;
  logic               alu_valid;
  logic               oitf_ena;
  logic               trap_ena;
  logic [XLEN-1:0]    trap_pc;
  rf_wbck_t           alu_req;

  exu_regfile u_regfile (
    .clk, .i_rst_n,
    .i_rs1idx (dec_info.rs1idx),
    .i_rs2idx (dec_info.rs2idx),
    .i_wbck   (o_wbck),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2)
  );

  exu_decode u_decode (.i_ir, .o_info(dec_info));

  exu_disp u_disp (
    .i_valid, .i_pc, .i_agu_cmd_ready, .o_ready, .o_agu_cmd_valid,
    .i_info      (dec_info),
    .i_oitf_full (oitf_full),
    .i_match_rs1 (match_rs1),
    .i_match_rs2 (match_rs2),
    .i_match_rd  (match_rd),
    .i_lsu_busy  (lsu_busy),
    .i_run       (run),
    .o_alu_valid (alu_valid),
    .o_oitf_ena  (oitf_ena),
    .o_trap_ena  (trap_ena),
    .o_trap_pc   (trap_pc)
  );

  exu_oitf #(.OITF_DEPTH(OITF_DEPTH)) u_oitf (
    .clk, .i_rst_n,
    .i_disp_ena   (oitf_ena),
    .i_disp_rdidx (dec_info.rdidx),
    .i_rs1en      (dec_info.rs1en),
    .i_rs1idx     (dec_info.rs1idx),
    .i_rs2en      (dec_info.rs2en),
    .i_rs2idx     (dec_info.rs2idx),
    .i_ret_ena    (ret_ena),
    .o_full       (oitf_full),
    .o_empty      (o_oitf_empty),
    .o_ret_rdidx  (ret_rdidx),
    .o_match_rs1  (match_rs1),
    .o_match_rs2  (match_rs2),
    .o_match_rd   (match_rd)
  );

  exu_alu u_alu (
    .i_valid    (alu_valid),
    .i_info     (dec_info),
    .i_rs1      (rf_rs1),
    .i_rs2      (rf_rs2),
    .o_wbck_req (alu_req),
    .o_agu_addr (o_agu_cmd_addr)
  );

  exu_wbck u_wbck (
    .i_lsu_valid, .i_lsu_wdat, .o_lsu_ready, .o_wbck,
    .i_alu_req    (alu_req),
    .i_oitf_empty (o_oitf_empty),
    .i_ret_rdidx  (ret_rdidx),
    .o_lsu_busy   (lsu_busy),
    .o_ret_ena    (ret_ena)
  );

  exu_commit u_commit (
    .clk, .i_rst_n, .i_flush_ack, .o_commit_trap, .o_flush_req, .o_flush_pc,
    .i_trap_ena   (trap_ena),
    .i_trap_pc    (trap_pc),
    .i_oitf_empty (o_oitf_empty),
    .o_run        (run)
  );

  // Busy with loads, new work, or a pending trap
  assign o_exu_active = ~o_oitf_empty | i_valid | ~run;

endmodule

/* logic/exu_wbck.sv */
/* Final write-back arbiter, long-pipe first.
   Load data goes to the destination held at the OITF head. */

`timescale 1ns/1ps

module exu_wbck import exu_pkg::*; (
  input  rf_wbck_t           i_alu_req,
  input  logic               i_lsu_valid,
  input  logic [XLEN-1:0]    i_lsu_wdat,
  input  logic               i_oitf_empty,
  input  logic [RFIDX_W-1:0] i_ret_rdidx,
  output logic               o_lsu_ready,
  output logic               o_lsu_busy,
  output logic               o_ret_ena,
  output rf_wbck_t           o_wbck
);

  assign o_lsu_ready = ~i_oitf_empty;           // Always wins the write port
  assign o_lsu_busy  = i_lsu_valid;             // Holds off ALU dispatch
  assign o_ret_ena   = i_lsu_valid & o_lsu_ready;

  always_comb begin
    if (o_ret_ena) begin
      o_wbck.ena  = (i_ret_rdidx != '0);        // LW to x0 retires silently
      o_wbck.idx  = i_ret_rdidx;
      o_wbck.wdat = i_lsu_wdat;
    end else begin
      o_wbck = i_alu_req;
    end
  end

endmodule

/* tb/tb_exu.sv */
/* Random instruction stream over x0..x7 with in-order load returns of varying latency.
   Load data is a fixed function of the address. Returns are held at first to fill the OITF. */

`timescale 1ns/1ps

module tb_exu;
  import exu_pkg::*;

  localparam int DEPTH   = 4;
  localparam int N_INSTR = 150;
  localparam int TMO     = 400;
  localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4;
  localparam int K_ADDI = 5, K_LW = 6, K_ILL = 7;

  logic clk = 1'b0;
  logic i_rst_n, i_valid, o_ready, i_agu_cmd_ready, o_agu_cmd_valid;
  logic i_lsu_valid, o_lsu_ready, o_flush_req, i_flush_ack, o_commit_trap;
  logic o_oitf_empty, o_exu_active;
  instr_t i_ir;
  logic [31:0] i_pc, o_agu_cmd_addr, i_lsu_wdat, o_flush_pc;
  rf_wbck_t o_wbck;

  exu_top #(.OITF_DEPTH(DEPTH)) uut (.*);

  always #2 clk = ~clk;

  // Model state, written only by the monitor
  logic [31:0] model_rf [32];
  logic [31:0] addr_q [$];
  logic [4:0]  pend_q [$];
  int cur_kind, cur_rd, cur_rs1, cur_rs2;
  logic [31:0] cur_imm, trap_pc;
  logic accepted = 1'b0, in_trap = 1'b0, trap_pulsed = 1'b0;
  int val_errs = 0, rule_errs = 0, n_ill = 0, n_traps = 0, lat_cnt = 0;
  int hold_cyc = 40;  // No load returns before this many falling edges

  task automatic value_err(input string name, input logic [31:0] exp, input logic [31:0] act);
    val_errs++;
    $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
  endtask

  task automatic rule_err(input string msg);
    rule_errs++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic abort_timeout(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $finish;
  endtask

  function automatic logic [31:0] load_data(input logic [31:0] a);
    return {a[15:0], ~a[31:16]} ^ (a * 32'h9e37_79b1);
  endfunction

  function automatic logic [31:0] alu_ref(input int k, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] imm);
    case (k)
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_AND:   return a & b;
      K_OR:    return a | b;
      K_XOR:   return a ^ b;
      default: return a + imm;
    endcase
  endfunction

  function automatic logic is_pending(input int idx);
    foreach (pend_q[i]) if (pend_q[i] == idx) return 1'b1;
    return 1'b0;
  endfunction

  function automatic instr_t make_ir(input int k, input int rd, input int rs1,
                                     input int rs2, input logic [11:0] imm);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (k == K_SUB) ? 7'b0100000 : 7'b0;
    f3 = (k == K_XOR) ? 3'b100 : (k == K_OR) ? 3'b110 : (k == K_AND) ? 3'b111 : 3'b000;
    if (k == K_ADDI) return {imm, 5'(rs1), 3'b000, 5'(rd), OPC_OPIMM};
    if (k == K_LW)   return {imm, 5'(rs1), 3'b010, 5'(rd), OPC_LOAD};
    if (k == K_ILL)  return {imm, 5'(rs1), 3'b000, 5'(rd), 7'b1110011};  // SYSTEM, unsupported
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  ////////////////////////////////////////////////////////////
  // Monitor, all checks on the rising edge
  always @(posedge clk) begin
    if (i_rst_n) begin
      assert (o_lsu_ready == (pend_q.size() != 0))
        else value_err("o_lsu_ready", pend_q.size() != 0, o_lsu_ready);
      assert (o_oitf_empty == (pend_q.size() == 0))
        else value_err("o_oitf_empty", pend_q.size() == 0, o_oitf_empty);
      assert (o_exu_active == (pend_q.size() != 0 || i_valid || in_trap))
        else value_err("o_exu_active", pend_q.size() != 0 || i_valid || in_trap, o_exu_active);
      assert (o_flush_req == (in_trap && (trap_pulsed || pend_q.size() == 0)))
        else value_err("o_flush_req", in_trap && (trap_pulsed || pend_q.size() == 0),
                       o_flush_req);
      assert (!(o_wbck.ena && o_wbck.idx == 0)) else rule_err("write to x0 on o_wbck");
      assert (!(in_trap && o_ready)) else rule_err("o_ready high during trap handling");
      if (o_agu_cmd_valid && i_agu_cmd_ready) begin
        assert (i_valid && o_ready && cur_kind == K_LW) else rule_err("command without load accept");
        assert (pend_q.size() < DEPTH) else rule_err("command issued with OITF full");
      end
      if (i_valid && o_ready) begin
        assert (!(cur_rs1 != 0 && cur_kind != K_ILL && is_pending(cur_rs1)))
          else rule_err("accepted with rs1 hazard on outstanding load");
        assert (!(cur_rs2 != 0 && cur_kind <= K_XOR && is_pending(cur_rs2)))
          else rule_err("accepted with rs2 hazard on outstanding load");
        assert (!(cur_rd != 0 && cur_kind != K_ILL && is_pending(cur_rd)))
          else rule_err("accepted with rd hazard on outstanding load");
        assert (!(i_lsu_valid && cur_kind <= K_ADDI))
          else rule_err("ALU accepted during load return");
      end
      // Trap pulse, seen against the loads outstanding before this edge
      if (o_commit_trap) begin
        assert (in_trap && !trap_pulsed && o_flush_req) else rule_err("unexpected trap pulse");
        assert (pend_q.size() == 0) else rule_err("trap before older loads wrote back");
        assert (o_flush_pc == trap_pc) else value_err("o_flush_pc", trap_pc, o_flush_pc);
        trap_pulsed = 1'b1;
        n_traps++;
      end
      // Load return
      if (i_lsu_valid && o_lsu_ready) begin
        assert (o_wbck.ena == (pend_q[0] != 0))
          else value_err("o_wbck.ena", pend_q[0] != 0, o_wbck.ena);
        if (pend_q[0] != 0) begin
          assert (o_wbck.idx == pend_q[0]) else value_err("o_wbck.idx", pend_q[0], o_wbck.idx);
          assert (o_wbck.wdat == load_data(addr_q[0]))
            else value_err("o_wbck.wdat", load_data(addr_q[0]), o_wbck.wdat);
          model_rf[pend_q[0]] = load_data(addr_q[0]);
        end
        void'(pend_q.pop_front());
        void'(addr_q.pop_front());
      end
      // Instruction accept
      if (i_valid && o_ready) begin
        accepted = 1'b1;
        if (cur_kind == K_LW) begin
          assert (o_agu_cmd_valid && i_agu_cmd_ready) else rule_err("load accepted without command");
          assert (o_agu_cmd_addr == model_rf[cur_rs1] + cur_imm)
            else value_err("o_agu_cmd_addr", model_rf[cur_rs1] + cur_imm, o_agu_cmd_addr);
          addr_q.push_back(model_rf[cur_rs1] + cur_imm);
          pend_q.push_back(5'(cur_rd));
        end else if (cur_kind == K_ILL) begin
          in_trap = 1'b1;
          trap_pulsed = 1'b0;
          trap_pc = i_pc;
          n_ill++;
        end else begin
          assert (o_wbck.ena == (cur_rd != 0))
            else value_err("o_wbck.ena", cur_rd != 0, o_wbck.ena);
          if (cur_rd != 0) begin
            assert (o_wbck.idx == cur_rd) else value_err("o_wbck.idx", cur_rd, o_wbck.idx);
            assert (o_wbck.wdat == alu_ref(cur_kind, model_rf[cur_rs1], model_rf[cur_rs2], cur_imm))
              else value_err("o_wbck.wdat",
                             alu_ref(cur_kind, model_rf[cur_rs1], model_rf[cur_rs2], cur_imm),
                             o_wbck.wdat);
            model_rf[cur_rd] = alu_ref(cur_kind, model_rf[cur_rs1], model_rf[cur_rs2], cur_imm);
          end
        end
      end
      if (o_flush_req && i_flush_ack && in_trap) in_trap = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Load responder, command ready and flush acknowledge
  always @(negedge clk) begin
    i_agu_cmd_ready <= ($urandom % 4) != 0;
    i_flush_ack     <= o_flush_req && (($urandom % 3) == 0);
    if (hold_cyc > 0) begin
      i_lsu_valid <= 1'b0;
      hold_cyc    <= hold_cyc - 1;
    end else if (lat_cnt == 0 && addr_q.size() > 0) begin
      i_lsu_valid <= 1'b1;
      i_lsu_wdat  <= load_data(addr_q[0]);
      lat_cnt     <= $urandom % 4;    // Gap before the next return
    end else begin
      i_lsu_valid <= 1'b0;
      if (lat_cnt > 0) lat_cnt <= lat_cnt - 1;
    end
  end

  // Presents the current instruction until accepted, then waits out a trap
  task automatic send_instr(input logic [31:0] pc);
    int cnt;
    i_ir    = make_ir(cur_kind, cur_rd, cur_rs1, cur_rs2, cur_imm[11:0]);
    i_pc    = pc;
    i_valid = 1'b1;
    cnt = 0;
    while (!accepted) begin
      @(negedge clk);
      if (++cnt > TMO) abort_timeout("instruction never accepted");
    end
    accepted = 1'b0;
    i_valid  = 1'b0;
    cnt = 0;
    while (in_trap) begin
      @(negedge clk);
      if (++cnt > TMO) abort_timeout("flush handshake never completed");
    end
  endtask

  task automatic issue(input int k, input logic [31:0] pc);
    cur_kind = k;
    cur_rd   = $urandom % 8;
    cur_rs1  = $urandom % 8;
    cur_rs2  = $urandom % 8;
    cur_imm  = {{20{1'b0}}, 12'($urandom)};
    cur_imm  = {{20{cur_imm[11]}}, cur_imm[11:0]};
    send_instr(pc);
  endtask

  // Load based on x0, so only its destination can collide
  task automatic issue_load(input int rd, input logic [31:0] pc);
    cur_kind = K_LW;
    cur_rd   = rd;
    cur_rs1  = 0;
    cur_rs2  = 0;
    cur_imm  = {{20{1'b0}}, 12'($urandom)};
    cur_imm  = {{20{cur_imm[11]}}, cur_imm[11:0]};
    send_instr(pc);
  endtask

  initial begin
    int cnt;
    int k;
    void'($urandom(32'hae4f9605));
    foreach (model_rf[i]) model_rf[i] = '0;
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_ir = '0;
    i_pc = '0;
    i_agu_cmd_ready = 1'b0;
    i_lsu_valid = 1'b0;
    i_lsu_wdat = '0;
    i_flush_ack = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (!o_agu_cmd_valid && !o_flush_req && !o_commit_trap && !o_wbck.ena && o_oitf_empty)
      else rule_err("outputs not at reset values");
    i_rst_n = 1'b1;
    // Independent loads fill the OITF and the last one waits for room
    for (int n = 0; n <= DEPTH; n++) issue_load(n + 1, 32'h80 + 4 * n);
    issue(K_ILL, 32'h80 + 4 * (DEPTH + 1));  // Trap behind outstanding loads
    for (int n = 0; n < N_INSTR; n++) begin
      k = $urandom % 16;
      k = (k >= 13) ? K_LW : (k == 12) ? ((n % 5 == 0) ? K_ILL : K_LW) : (k % 6);
      issue(k, 32'h100 + 4 * n);
      if (($urandom % 4) == 0) @(negedge clk);
    end
    cnt = 0;
    while (pend_q.size() != 0 || !o_oitf_empty) begin
      @(negedge clk);
      if (++cnt > TMO) abort_timeout("outstanding loads never drained");
    end
    assert (n_traps == n_ill) else rule_err("trap pulse count differs from illegal count");
    $display("Done: %0d value errors, %0d other errors", val_errs, rule_errs);
    if (val_errs == 0 && rule_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
